// ==== sim.f ====
rtl/core_pkg.sv
rtl/entry_queue.sv
rtl/decode_riscv.sv
rtl/decode_ctrl.sv
rtl/cycle_accounting.sv
rtl/decode_stage.sv
verification/decode_stage_tb.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = decode_stage_tb
FILELIST = sim.f
LOG = sim.log
BIN = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if grep -q "Simulation completed successfully" $(LOG); then echo "PASS"; \
	else echo "FAIL"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb;
	localparam int N_DEC = 21; // rows that decode without serializing
	localparam int ROW_BREAK = 21;
	localparam int ROW_MONITOR = 22;
	localparam int LIMIT = 200; // cycles allowed per wait
	localparam int F_MEM = 1;
	localparam int F_ST = 2;
	localparam int F_BR = 4;
	localparam int F_PRED = 8; // direction taken from fetch
	localparam int F_TAKEN = 16;
	localparam int F_SER = 32;

	typedef struct packed
	{
		logic [31:0] insn;
		core_pkg::opcode_t op;
		logic [core_pkg::LG_PRF_ENTRIES-1:0] dst;
		logic dst_valid;
		logic [core_pkg::LG_PRF_ENTRIES-1:0] srcA;
		logic srcA_valid;
		logic [core_pkg::LG_PRF_ENTRIES-1:0] srcB;
		logic srcB_valid;
		logic [31:0] rvimm;
		logic is_mem;
		logic is_store;
		logic is_br;
		logic br_follows;
		logic br_taken;
		logic ser;
	} row_t;

	typedef struct
	{
		int row;
		logic pred;
		logic [core_pkg::M_WIDTH-1:0] pc;
		logic [core_pkg::LG_PHT_SZ-1:0] pht;
		logic [core_pkg::CYCLE_W-1:0] cycle;
	} exp_t;

	logic clk;
	logic reset;
	logic fetch_push;
	logic [31:0] insn;
	logic [core_pkg::M_WIDTH-1:0] pc;
	logic insn_pred;
	logic [core_pkg::LG_PHT_SZ-1:0] pht_idx;
	logic [core_pkg::M_WIDTH-1:0] insn_pred_target;
	logic uop_pop;
	logic rob_empty;
	logic fetch_full;
	logic uop_valid;
	core_pkg::uop_t uop;
	logic redirect;
	logic [core_pkg::M_WIDTH-1:0] redirect_pc;
	logic [core_pkg::CYCLE_W-1:0] cycle_count;
	logic [core_pkg::CYCLE_W-1:0] stall_count;

	row_t rows [ROW_MONITOR+1];
	int n_rows;
	exp_t sb [$]; // pushes still owed by the DUT
	logic [15:0] stim_lfsr;
	logic [15:0] gap_lfsr;
	int checks;
	int errors;
	int tests;
	int t_checks;
	int t_errors;
	logic pop_en;
	int max_gap_bits;
	int gap;
	int redirects;
	logic [core_pkg::M_WIDTH-1:0] redirect_seen;
	logic [core_pkg::M_WIDTH-1:0] next_pc;
	logic [core_pkg::M_WIDTH-1:0] mon_pc;
	logic [core_pkg::CYCLE_W-1:0] s0;
	logic [core_pkg::CYCLE_W-1:0] c0;
	int accepted;

	decode_stage UUT
	(
		.clk(clk),
		.reset(reset),
		.fetch_push(fetch_push),
		.insn(insn),
		.pc(pc),
		.insn_pred(insn_pred),
		.pht_idx(pht_idx),
		.insn_pred_target(insn_pred_target),
		.uop_pop(uop_pop),
		.rob_empty(rob_empty),
		.fetch_full(fetch_full),
		.uop_valid(uop_valid),
		.uop(uop),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.cycle_count(cycle_count),
		.stall_count(stall_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(inout logic [15:0] state, input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			state = lfsr_step(state);
			v = (v << 1) | {31'd0, state[0]}; // one step per bit
		end
	endtask

	task automatic add_row(input logic [31:0] w, input core_pkg::opcode_t op, input int d,
		input int a, input int b, input logic [31:0] imm, input int flags);
		row_t r;
		r.insn = w;
		r.op = op;
		r.dst_valid = (d >= 0);
		r.dst = r.dst_valid ? d[core_pkg::LG_PRF_ENTRIES-1:0] : '0; // -1 means unused
		r.srcA_valid = (a >= 0);
		r.srcA = r.srcA_valid ? a[core_pkg::LG_PRF_ENTRIES-1:0] : '0;
		r.srcB_valid = (b >= 0);
		r.srcB = r.srcB_valid ? b[core_pkg::LG_PRF_ENTRIES-1:0] : '0;
		r.rvimm = imm;
		r.is_mem = (flags & F_MEM) != 0;
		r.is_store = (flags & F_ST) != 0;
		r.is_br = (flags & F_BR) != 0;
		r.br_follows = (flags & F_PRED) != 0;
		r.br_taken = (flags & F_TAKEN) != 0;
		r.ser = (flags & F_SER) != 0;
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic fill_rows();
		n_rows = 0;
		add_row(32'h00812283, core_pkg::LW, 5, 2, -1, 32'h8, F_MEM);
		add_row(32'hFFC1C303, core_pkg::LBU, 6, 3, -1, 32'hFFFFFFFC, F_MEM);
		add_row(32'h00742623, core_pkg::SW, -1, 8, 7, 32'hC, F_MEM | F_ST);
		add_row(32'hFE950FA3, core_pkg::SB, -1, 10, 9, 32'hFFFFFFFF, F_MEM | F_ST);
		add_row(32'h06400093, core_pkg::ADDI, 1, 0, -1, 32'h64, 0);
		add_row(32'h40525193, core_pkg::SRAI, 3, 4, -1, 32'h405, 0); // shamt in imm
		add_row(32'h002081B3, core_pkg::ADDU, 3, 1, 2, 32'h0, 0);
		add_row(32'h40628233, core_pkg::SUBU, 4, 5, 6, 32'h0, 0);
		add_row(32'h02C58533, core_pkg::MUL, 10, 11, 12, 32'h0, 0);
		add_row(32'h02F756B3, core_pkg::DIVU, 13, 14, 15, 32'h0, 0);
		add_row(32'h123452B7, core_pkg::LUI, 5, -1, -1, 32'h12345000, 0);
		add_row(32'hFFFFF317, core_pkg::AUIPC, 6, -1, -1, 32'hFFFFF000, 0);
		add_row(32'h00208863, core_pkg::BEQ, -1, 1, 2, 32'h10, F_BR | F_PRED);
		add_row(32'hFE419CE3, core_pkg::BNE, -1, 3, 4, 32'hFFFFFFF8, F_BR | F_PRED);
		add_row(32'h0010006F, core_pkg::J, -1, -1, -1, 32'h800, F_BR | F_TAKEN);
		add_row(32'hFFDFF0EF, core_pkg::JAL, 1, -1, -1, 32'hFFFFFFFC, F_BR | F_TAKEN);
		add_row(32'h00030067, core_pkg::JR, -1, 6, -1, 32'h0, F_BR | F_TAKEN);
		add_row(32'h00008067, core_pkg::RET, -1, 1, -1, 32'h0, F_BR | F_TAKEN);
		add_row(32'h004380E7, core_pkg::JALR, 1, 7, -1, 32'h4, F_BR | F_TAKEN);
		add_row(32'h00108013, core_pkg::NOP, -1, 1, -1, 32'h1, 0); // addi x0
		add_row(32'hFFFFFFFF, core_pkg::II, -1, -1, -1, 32'h0, 0);
		add_row(32'h00000073, core_pkg::BREAK, -1, -1, -1, 32'h0, F_SER);
		add_row(32'h00100073, core_pkg::MONITOR, -1, -1, -1, 32'h0, F_SER);
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input logic [core_pkg::M_WIDTH-1:0] got,
		input logic [core_pkg::M_WIDTH-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input logic [core_pkg::CYCLE_W-1:0] got,
		input logic [core_pkg::CYCLE_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_uop(input core_pkg::uop_t got, input exp_t e);
		core_pkg::uop_t want;
		row_t r;
		r = rows[e.row];
		want = got; // fields outside the table are taken as seen
		want.op = r.op;
		want.dst = r.dst;
		want.dst_valid = r.dst_valid;
		want.srcA = r.srcA;
		want.srcA_valid = r.srcA_valid;
		want.srcB = r.srcB;
		want.srcB_valid = r.srcB_valid;
		want.rvimm = r.rvimm;
		want.is_mem = r.is_mem;
		want.is_store = r.is_store;
		want.is_br = r.is_br;
		want.br_pred = r.br_follows ? e.pred : r.br_taken;
		want.serializing_op = r.ser;
		want.must_restart = (r.op == core_pkg::MONITOR);
		want.fp_srcA_valid = 1'b0;
		want.fp_srcB_valid = 1'b0;
		want.fp_dst_valid = 1'b0;
		want.pc = e.pc;
		want.pht_idx = e.pht;
		want.fetch_cycle = e.cycle;
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("Mismatch at %0t: insn %h gave %s, got %h expected %h",
				$time, r.insn, got.op.name(), got, want);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	// called at a falling edge, returns one falling edge later
	task automatic push_row(input int r, input logic keep);
		exp_t e;
		int t;
		int v;
		t = 0;
		while (fetch_full && t < LIMIT)
		begin
			@(negedge clk);
			t++;
		end
		if (fetch_full)
			fail_timeout("room in the fetch queue");
		draw_bits(stim_lfsr, 1, v);
		insn_pred = v[0];
		draw_bits(stim_lfsr, core_pkg::LG_PHT_SZ, v);
		pht_idx = v[core_pkg::LG_PHT_SZ-1:0];
		fetch_push = 1'b1;
		insn = rows[r].insn;
		pc = next_pc;
		insn_pred_target = next_pc + 32'h40;
		e.row = r;
		e.pred = insn_pred;
		e.pc = next_pc;
		e.pht = pht_idx;
		e.cycle = cycle_count; // stamp the DUT takes at the next edge
		if (keep)
			sb.push_back(e);
		next_pc = next_pc + 32'd4;
		@(negedge clk);
		fetch_push = 1'b0;
	endtask

	task automatic wait_sb(input int n, input string what);
		int t;
		t = 0;
		while (sb.size() > n && t < LIMIT)
		begin
			@(negedge clk);
			t++;
		end
		if (sb.size() > n)
			fail_timeout(what);
	endtask

	task automatic start_test();
		t_checks = checks;
		t_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
	endtask

	// consumer pops and checks against the push record
	initial
	begin
		uop_pop = 1'b0;
		forever
		begin
			@(negedge clk);
			uop_pop = 1'b0;
			if (redirect)
			begin
				redirects++;
				redirect_seen = redirect_pc;
			end
			if (uop_valid && pop_en)
			begin
				if (gap > 0)
					gap--;
				else if (sb.size() == 0)
				begin
					errors++;
					$display("Unexpected micro-op %s at %0t that matches no push",
						uop.op.name(), $time);
					uop_pop = 1'b1;
				end
				else
				begin
					check_uop(uop, sb.pop_front());
					uop_pop = 1'b1;
					draw_bits(gap_lfsr, max_gap_bits, gap);
				end
			end
		end
	end

	initial
	begin
		reset = 1'b1;
		fetch_push = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		insn_pred_target = '0;
		rob_empty = 1'b1;
		pop_en = 1'b0;
		max_gap_bits = 0;
		gap = 0;
		redirects = 0;
		redirect_seen = '0;
		next_pc = 32'h0000_1000;
		stim_lfsr = 16'd12305;
		gap_lfsr = 16'd12305;
		checks = 0;
		errors = 0;
		tests = 0;
		fill_rows();
		repeat (4) @(posedge clk);
		@(negedge clk);
		start_test();
		check_flag("fetch_full in reset", fetch_full, 1'b0);
		check_flag("uop_valid in reset", uop_valid, 1'b0);
		check_flag("redirect in reset", redirect, 1'b0);
		check_count("cycle_count in reset", cycle_count, '0);
		check_count("stall_count in reset", stall_count, '0);
		reset = 1'b0;
		end_test("reset");

		start_test();
		pop_en = 1'b1;
		for (int r = 0; r < N_DEC; r++)
		begin
			push_row(r, 1'b1);
			check_flag("uop_valid one edge after push", uop_valid, 1'b0);
			@(negedge clk);
			check_flag("uop_valid two edges after push", uop_valid, 1'b1);
			wait_sb(0, "a decoded micro-op");
		end
		end_test("decode table");

		start_test();
		max_gap_bits = 2;
		for (int r = 0; r < 12; r++)
			push_row(r, 1'b1);
		wait_sb(0, "the burst to drain");
		end_test("order and metadata");

		start_test();
		pop_en = 1'b0;
		gap = 0;
		accepted = 0;
		while (!fetch_full && accepted < LIMIT)
		begin
			push_row(accepted % N_DEC, 1'b1);
			accepted++;
		end
		check_count("pushes accepted before fetch_full", 64'(accepted),
			64'(core_pkg::FQ_DEPTH + core_pkg::UQ_DEPTH));
		s0 = stall_count;
		c0 = cycle_count;
		repeat (6) @(negedge clk); // every cycle stalls with both queues full
		check_count("stall cycles while held", stall_count - s0, 64'd6);
		check_count("cycles counted while held", cycle_count - c0, 64'd6);
		pop_en = 1'b1;
		wait_sb(0, "the held micro-ops to drain");
		end_test("back-pressure");

		start_test();
		max_gap_bits = 0;
		rob_empty = 1'b0;
		push_row(6, 1'b1);
		push_row(7, 1'b1);
		push_row(ROW_BREAK, 1'b1);
		wait_sb(1, "the ALU ops ahead of BREAK");
		repeat (10)
		begin
			@(negedge clk);
			check_flag("uop_valid while the ROB is busy", uop_valid, 1'b0);
		end
		rob_empty = 1'b1;
		wait_sb(0, "BREAK after rob_empty");
		end_test("serializing");

		start_test();
		redirects = 0;
		mon_pc = next_pc;
		push_row(ROW_MONITOR, 1'b1);
		push_row(6, 1'b0); // younger ops are flushed
		push_row(7, 1'b0);
		wait_sb(0, "MONITOR");
		repeat (8) @(negedge clk);
		check_count("redirect pulses", 64'(redirects), 64'd1);
		check_addr("redirect_pc", redirect_seen, mon_pc + 32'd4);
		check_flag("uop_valid after restart", uop_valid, 1'b0);
		end_test("restart");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end
endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
(
	input logic clk,
	input logic reset,
	input logic fetch_push,
	input logic [31:0] insn,
	input logic [core_pkg::M_WIDTH-1:0] pc,
	input logic insn_pred,
	input logic [core_pkg::LG_PHT_SZ-1:0] pht_idx,
	input logic [core_pkg::M_WIDTH-1:0] insn_pred_target,
	input logic uop_pop,
	input logic rob_empty,
	output logic fetch_full,
	output logic uop_valid,
	output core_pkg::uop_t uop,
	output logic redirect,
	output logic [core_pkg::M_WIDTH-1:0] redirect_pc,
	output logic [core_pkg::CYCLE_W-1:0] cycle_count,
	output logic [core_pkg::CYCLE_W-1:0] stall_count
);
	core_pkg::fetch_t fq_in;
	core_pkg::fetch_t fq_head;
	core_pkg::uop_t dec_uop;
	logic fq_empty;
	logic uq_empty;
	logic uq_full;
	logic advance;
	logic flush;
	logic stall;

	assign fq_in.insn = insn;
	assign fq_in.pc = pc;
	assign fq_in.insn_pred = insn_pred;
	assign fq_in.pht_idx = pht_idx;
	assign fq_in.insn_pred_target = insn_pred_target;
	assign fq_in.fetch_cycle = cycle_count; // stamp with current cycle

	assign uop_valid = !uq_empty;
	assign redirect_pc = fq_head.pc + core_pkg::INSN_BYTES; // restart after head

	entry_queue #(.payload_t(core_pkg::fetch_t), .DEPTH(core_pkg::FQ_DEPTH)) fq
	(
		.clk(clk),
		.reset(reset),
		.push(fetch_push),
		.pop(advance),
		.flush(flush),
		.din(fq_in),
		.dout(fq_head),
		.empty(fq_empty),
		.full(fetch_full)
	);

	decode_riscv dec
	(
		.insn(fq_head.insn),
		.pc(fq_head.pc),
		.insn_pred(fq_head.insn_pred),
		.pht_idx(fq_head.pht_idx),
		.insn_pred_target(fq_head.insn_pred_target),
		.fetch_cycle(fq_head.fetch_cycle),
		.uop(dec_uop)
	);

	decode_ctrl ctrl
	(
		.clk(clk),
		.reset(reset),
		.fq_empty(fq_empty),
		.uq_empty(uq_empty),
		.uq_full(uq_full),
		.serializing(dec_uop.serializing_op),
		.must_restart(dec_uop.must_restart),
		.rob_empty(rob_empty),
		.advance(advance),
		.flush(flush),
		.redirect(redirect),
		.stall(stall)
	);

	entry_queue #(.payload_t(core_pkg::uop_t), .DEPTH(core_pkg::UQ_DEPTH)) uq
	(
		.clk(clk),
		.reset(reset),
		.push(advance),
		.pop(uop_pop),
		.flush(1'b0),
		.din(dec_uop),
		.dout(uop),
		.empty(uq_empty),
		.full(uq_full)
	);

	cycle_accounting acct
	(
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.cycle_count(cycle_count),
		.stall_count(stall_count)
	);
endmodule

// ==== rtl/cycle_accounting.sv ====
`timescale 1ns/100ps

module cycle_accounting
(
	input logic clk,
	input logic reset,
	input logic stall,
	output logic [core_pkg::CYCLE_W-1:0] cycle_count,
	output logic [core_pkg::CYCLE_W-1:0] stall_count
);
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cycle_count <= '0;
			stall_count <= '0;
		end
		else
		begin
			cycle_count <= cycle_count + 1'b1; // free running
			if (stall)
				stall_count <= stall_count + 1'b1;
		end
	end
endmodule

// ==== rtl/decode_ctrl.sv ====
`timescale 1ns/100ps

module decode_ctrl
(
	input logic clk,
	input logic reset,
	input logic fq_empty,
	input logic uq_empty,
	input logic uq_full,
	input logic serializing,
	input logic must_restart,
	input logic rob_empty,
	output logic advance,
	output logic flush,
	output logic redirect,
	output logic stall
);
	typedef enum logic {RUN, DRAIN} state_t;

	state_t state;
	state_t next_state;

	always_comb
	begin
		next_state = state;
		advance = 1'b0;
		flush = 1'b0;
		redirect = 1'b0;
		case (state)
		RUN:
		begin
			if (!fq_empty && serializing)
				next_state = DRAIN; // hold head until machine is quiet
			else if (!fq_empty && !uq_full)
				advance = 1'b1;
		end
		default:
		begin
			if (uq_empty && rob_empty)
			begin
				advance = 1'b1;
				flush = must_restart; // drop younger fetched entries
				redirect = must_restart;
				next_state = RUN;
			end
		end
		endcase
	end

	assign stall = !fq_empty && !advance;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= RUN;
		else
			state <= next_state;
	end
endmodule

// ==== rtl/decode_riscv.sv ====
`timescale 1ns/100ps

module decode_riscv
(
	input logic [31:0] insn,
	input logic [core_pkg::M_WIDTH-1:0] pc,
	input logic insn_pred,
	input logic [core_pkg::LG_PHT_SZ-1:0] pht_idx,
	input logic [core_pkg::M_WIDTH-1:0] insn_pred_target,
	input logic [core_pkg::CYCLE_W-1:0] fetch_cycle,
	output core_pkg::uop_t uop
);
	wire [6:0] opcode = insn[6:0];
	wire [2:0] funct3 = insn[14:12];
	wire [6:0] funct7 = insn[31:25];
	wire [core_pkg::LG_PRF_ENTRIES-1:0] rd =
		{{(core_pkg::LG_PRF_ENTRIES-5){1'b0}}, insn[11:7]};
	wire [core_pkg::LG_PRF_ENTRIES-1:0] rs1 =
		{{(core_pkg::LG_PRF_ENTRIES-5){1'b0}}, insn[19:15]};
	wire [core_pkg::LG_PRF_ENTRIES-1:0] rs2 =
		{{(core_pkg::LG_PRF_ENTRIES-5){1'b0}}, insn[24:20]};
	wire rs1_is_link = (insn[19:15] == 5'd1) || (insn[19:15] == 5'd5); // ra or t0

	wire [31:0] imm_i = {{20{insn[31]}}, insn[31:20]};
	wire [31:0] imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	wire [31:0] imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	wire [31:0] imm_u = {insn[31:12], 12'd0};
	wire [31:0] imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	logic writes_rd;

	always_comb
	begin
		uop = '0; // fp valids and rob_ptr stay zero
		uop.op = core_pkg::II;
		uop.pc = pc;
		uop.pht_idx = pht_idx;
		uop.fetch_cycle = fetch_cycle;
		writes_rd = 1'b0;
		case (opcode)
		7'h03:
		begin
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.srcA = rs1;
			uop.srcA_valid = 1'b1;
			uop.is_mem = 1'b1;
			uop.rvimm = imm_i;
			writes_rd = 1'b1;
			case (funct3)
			3'd0: uop.op = core_pkg::LB;
			3'd1: uop.op = core_pkg::LH;
			3'd2: uop.op = core_pkg::LW;
			3'd4: uop.op = core_pkg::LBU;
			3'd5: uop.op = core_pkg::LHU;
			default: uop.op = core_pkg::II;
			endcase
		end
		7'h0f: uop.op = core_pkg::NOP; // fence
		7'h13:
		begin
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.srcA = rs1;
			uop.srcA_valid = 1'b1;
			uop.is_int = 1'b1;
			uop.rvimm = imm_i;
			writes_rd = 1'b1;
			case (funct3)
			3'd0: uop.op = core_pkg::ADDI;
			3'd1: uop.op = (funct7 == 7'h00) ? core_pkg::SLLI : core_pkg::II;
			3'd2: uop.op = core_pkg::SLTI;
			3'd3: uop.op = core_pkg::SLTIU;
			3'd4: uop.op = core_pkg::XORI;
			3'd5:
			begin
				if (funct7 == 7'h00)
					uop.op = core_pkg::SRLI;
				else if (funct7 == 7'h20)
					uop.op = core_pkg::SRAI;
			end
			3'd6: uop.op = core_pkg::ORI;
			default: uop.op = core_pkg::ANDI;
			endcase
		end
		7'h17, 7'h37:
		begin
			uop.op = insn[5] ? core_pkg::LUI : core_pkg::AUIPC;
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.is_int = 1'b1;
			uop.rvimm = imm_u;
			writes_rd = 1'b1;
		end
		7'h23:
		begin
			uop.srcA = rs1;
			uop.srcA_valid = 1'b1;
			uop.srcB = rs2;
			uop.srcB_valid = 1'b1;
			uop.is_mem = 1'b1;
			uop.is_store = 1'b1;
			uop.rvimm = imm_s;
			case (funct3)
			3'd0: uop.op = core_pkg::SB;
			3'd1: uop.op = core_pkg::SH;
			3'd2: uop.op = core_pkg::SW;
			default: uop.op = core_pkg::II;
			endcase
		end
		7'h33:
		begin
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.srcA = rs1;
			uop.srcA_valid = 1'b1;
			uop.srcB = rs2;
			uop.srcB_valid = 1'b1;
			uop.is_int = 1'b1;
			writes_rd = 1'b1;
			case ({funct7, funct3})
			{7'h00, 3'd0}: uop.op = core_pkg::ADDU;
			{7'h20, 3'd0}: uop.op = core_pkg::SUBU;
			{7'h00, 3'd1}: uop.op = core_pkg::SLL;
			{7'h00, 3'd2}: uop.op = core_pkg::SLT;
			{7'h00, 3'd3}: uop.op = core_pkg::SLTU;
			{7'h00, 3'd4}: uop.op = core_pkg::XOR;
			{7'h00, 3'd5}: uop.op = core_pkg::SRL;
			{7'h20, 3'd5}: uop.op = core_pkg::SRA;
			{7'h00, 3'd6}: uop.op = core_pkg::OR;
			{7'h00, 3'd7}: uop.op = core_pkg::AND;
			{7'h01, 3'd0}: uop.op = core_pkg::MUL;
			{7'h01, 3'd1}: uop.op = core_pkg::MULH;
			{7'h01, 3'd2}: uop.op = core_pkg::MULHSU;
			{7'h01, 3'd3}: uop.op = core_pkg::MULHU;
			{7'h01, 3'd4}: uop.op = core_pkg::DIV;
			{7'h01, 3'd5}: uop.op = core_pkg::DIVU;
			{7'h01, 3'd6}: uop.op = core_pkg::REM;
			{7'h01, 3'd7}: uop.op = core_pkg::REMU;
			default: uop.op = core_pkg::II;
			endcase
		end
		7'h63:
		begin
			uop.srcA = rs1;
			uop.srcA_valid = 1'b1;
			uop.srcB = rs2;
			uop.srcB_valid = 1'b1;
			uop.is_int = 1'b1;
			uop.is_br = 1'b1;
			uop.br_pred = insn_pred; // direction from fetch predictor
			uop.rvimm = imm_b;
			case (funct3)
			3'd0: uop.op = core_pkg::BEQ;
			3'd1: uop.op = core_pkg::BNE;
			3'd4: uop.op = core_pkg::BLT;
			3'd5: uop.op = core_pkg::BGE;
			3'd6: uop.op = core_pkg::BLTU;
			3'd7: uop.op = core_pkg::BGEU;
			default: uop.op = core_pkg::II;
			endcase
		end
		7'h67:
		begin
			uop.srcA = rs1;
			uop.srcA_valid = 1'b1;
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.is_int = 1'b1;
			uop.is_br = 1'b1;
			uop.br_pred = 1'b1;
			uop.rvimm = imm_i;
			uop.imm = insn_pred_target[15:0]; // predicted target split over imm fields
			uop.jmp_imm = insn_pred_target[core_pkg::M_WIDTH-1:16];
			if (rd != '0)
				uop.op = core_pkg::JALR;
			else
				uop.op = rs1_is_link ? core_pkg::RET : core_pkg::JR;
		end
		7'h6f:
		begin
			uop.op = (rd == '0) ? core_pkg::J : core_pkg::JAL;
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			uop.is_int = 1'b1;
			uop.is_br = 1'b1;
			uop.br_pred = 1'b1;
			uop.rvimm = imm_j;
		end
		7'h73:
		begin
			uop.is_int = 1'b1;
			uop.op = core_pkg::NOP; // other system ops ignored
			if (insn[31:7] == '0)
			begin
				uop.op = core_pkg::BREAK;
				uop.serializing_op = 1'b1;
			end
			else if (insn[31:20] == 12'd1 && insn[19:7] == '0)
			begin
				uop.op = core_pkg::MONITOR;
				uop.serializing_op = 1'b1;
				uop.must_restart = 1'b1;
			end
		end
		default: uop.op = core_pkg::II;
		endcase
		if (writes_rd && rd == '0 && uop.op != core_pkg::II)
			uop.op = core_pkg::NOP; // result to x0 is dropped
	end
endmodule

// ==== rtl/entry_queue.sv ====
`timescale 1ns/100ps

module entry_queue
#(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic flush,
	input payload_t din,
	output payload_t dout,
	output logic empty,
	output logic full
);
	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	wire do_push = push && !full && !flush; // flush wins over push
	wire do_pop = pop && !empty && !flush;

	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == DEPTH);

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count; // both or neither
			endcase
		end
	end
endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;
	localparam int M_WIDTH = 32;
	localparam int LG_PHT_SZ = 8;
	localparam int LG_PRF_ENTRIES = 6;
	localparam int LG_ROB_ENTRIES = 5;
	localparam int FQ_DEPTH = 4;
	localparam int UQ_DEPTH = 4;
	localparam int CYCLE_W = 64;
	localparam logic [M_WIDTH-1:0] INSN_BYTES = 4; // fall-through pc step

	typedef enum logic [5:0]
	{
		II,
		NOP,
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW,
		ADDI,
		SLTI,
		SLTIU,
		XORI,
		ORI,
		ANDI,
		SLLI,
		SRLI,
		SRAI,
		AUIPC,
		LUI,
		ADDU,
		SUBU,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		MUL,
		MULH,
		MULHSU,
		MULHU,
		DIV,
		DIVU,
		REM,
		REMU,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU,
		J,
		JAL,
		JR,
		JALR,
		RET,
		BREAK,
		MONITOR
	} opcode_t;

	typedef struct packed
	{
		opcode_t op;
		logic [LG_PRF_ENTRIES-1:0] srcA;
		logic srcA_valid;
		logic fp_srcA_valid;
		logic [LG_PRF_ENTRIES-1:0] srcB;
		logic srcB_valid;
		logic fp_srcB_valid;
		logic [LG_PRF_ENTRIES-1:0] dst;
		logic dst_valid;
		logic fp_dst_valid;
		logic [15:0] imm;
		logic [M_WIDTH-17:0] jmp_imm; // upper bits of predicted target
		logic [31:0] rvimm;
		logic [M_WIDTH-1:0] pc;
		logic serializing_op;
		logic must_restart;
		logic [LG_ROB_ENTRIES-1:0] rob_ptr;
		logic br_pred;
		logic is_br;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic is_mem;
		logic is_int;
		logic is_store;
		logic [CYCLE_W-1:0] fetch_cycle;
	} uop_t;

	typedef struct packed
	{
		logic [31:0] insn;
		logic [M_WIDTH-1:0] pc;
		logic insn_pred;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic [M_WIDTH-1:0] insn_pred_target;
		logic [CYCLE_W-1:0] fetch_cycle; // stamp at push time
	} fetch_t;
endpackage
